//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_frame_generator
FILE_LIST ?= sim.f
BUILD_DIR ?= build
LOG_FILE  ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT := All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG_FILE) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG_FILE)"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG_FILE VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG_FILE)
	@grep -q "$(PASS_TEXT)" $(LOG_FILE) || \
		(echo "Simulation failed, see $(LOG_FILE)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)

//--- hw/byte_stream_if.sv
`include "frame_params.svh"

interface byte_stream_if;

    logic [`FRAME_BYTE_WIDTH-1:0] data;
    logic                         valid;
    logic                         ready;
    logic                         last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface

//--- hw/fcs_appender.sv
`include "frame_params.svh"

module fcs_appender (
    input  logic          clock,
    input  logic          reset_n,
    byte_stream_if.sink   upstream,
    byte_stream_if.source downstream
);

    logic [31:0] crc;
    logic [1:0]  fcs_index;
    logic        fcs_active;
    logic        out_free;
    logic        in_fire;

    // One byte of reflected CRC-32, LSB first
    function automatic logic [31:0] crc32_byte(
        input logic [31:0]                  crc_in,
        input logic [`FRAME_BYTE_WIDTH-1:0] data_in
    );
        logic [31:0] c;
        int          bit_index;
        c = crc_in ^ 32'(data_in);
        for (bit_index = 0; bit_index < 8; bit_index++) begin
            c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign out_free       = !downstream.valid || downstream.ready;
    assign upstream.ready = !fcs_active && out_free;
    assign in_fire        = upstream.valid && upstream.ready;

    //////////////////////////////////////////////////////////////////////
    // Forwarding and FCS emission

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            downstream.valid <= 1'b0;
            downstream.last  <= 1'b0;
            fcs_active       <= 1'b0;
            fcs_index        <= '0;
            crc              <= `CRC32_INIT;
        end else if (in_fire) begin
            downstream.valid <= 1'b1;
            downstream.last  <= 1'b0;
            crc              <= crc32_byte(crc, upstream.data);
            fcs_active       <= upstream.last;
            fcs_index        <= '0;
        end else if (fcs_active && out_free) begin
            downstream.valid <= 1'b1;
            downstream.last  <= fcs_index == 2'd3;
            fcs_index        <= fcs_index + 2'd1;
            if (fcs_index == 2'd3) begin
                fcs_active <= 1'b0;
                crc        <= `CRC32_INIT;
            end
        end else if (downstream.ready) begin
            downstream.valid <= 1'b0;
            downstream.last  <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (in_fire) begin
            downstream.data <= upstream.data;
        end else if (fcs_active && out_free) begin
            downstream.data <= ~crc[8 * fcs_index +: 8];
        end
    end

endmodule

//--- hw/frame_generator_top.sv
`include "frame_params.svh"

module frame_generator_top (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          start_valid,
    output logic                          start_ready,
    input  frame_pkg::mac_addr_t          mac_destination,
    input  frame_pkg::mac_addr_t          mac_source,
    input  frame_pkg::ipv4_addr_t         ipv4_source,
    input  frame_pkg::ipv4_addr_t         ipv4_destination,
    input  logic [15:0]                   ipv4_identification,
    input  logic [15:0]                   ipv4_flags,
    input  logic [15:0]                   udp_checksum,
    input  logic [15:0]                   payload_length,
    input  frame_pkg::udp_port_t          udp_source,
    input  frame_pkg::udp_port_t          udp_destination,
    output logic [`BUFFER_ADDR_WIDTH-1:0] buffer_address,
    input  logic [`FRAME_BYTE_WIDTH-1:0]  buffer_data,
    output logic [`FRAME_BYTE_WIDTH-1:0]  out_data,
    output logic                          out_valid,
    output logic                          out_last,
    input  logic                          out_ready
);

    frame_pkg::frame_request_t request;

    byte_stream_if hdr_stream ();
    byte_stream_if fcs_stream ();
    byte_stream_if out_stream ();

    assign request = '{
        mac_destination:  mac_destination,
        mac_source:       mac_source,
        ipv4_source:      ipv4_source,
        ipv4_destination: ipv4_destination,
        identification:   ipv4_identification,
        flags:            ipv4_flags,
        udp_source:       udp_source,
        udp_destination:  udp_destination,
        udp_checksum:     udp_checksum,
        payload_length:   payload_length
    };

    header_serializer i_header_serializer (
        .clock          (clock),
        .reset_n        (reset_n),
        .start_valid    (start_valid),
        .start_ready    (start_ready),
        .request        (request),
        .buffer_address (buffer_address),
        .buffer_data    (buffer_data),
        .stream         (hdr_stream.source)
    );

    fcs_appender i_fcs_appender (
        .clock      (clock),
        .reset_n    (reset_n),
        .upstream   (hdr_stream.sink),
        .downstream (fcs_stream.source)
    );

    preamble_inserter i_preamble_inserter (
        .clock      (clock),
        .reset_n    (reset_n),
        .upstream   (fcs_stream.sink),
        .downstream (out_stream.source)
    );

    assign out_data         = out_stream.data;
    assign out_valid        = out_stream.valid;
    assign out_last         = out_stream.last;
    assign out_stream.ready = out_ready;

endmodule

//--- hw/frame_params.svh
`ifndef FRAME_PARAMS_SVH
`define FRAME_PARAMS_SVH

// Stream and buffer widths
`define FRAME_BYTE_WIDTH        8
`define BUFFER_ADDR_WIDTH       11

// Ethernet framing
`define MIN_PAYLOAD_BYTES       18
`define PREAMBLE_BYTES          7
`define PREAMBLE_BYTE           8'h55
`define SFD_BYTE                8'hD5
`define ETHERTYPE_IPV4          16'h0800

// Fixed IPv4 and UDP header values
`define IPV4_VERSION_IHL        8'h45
`define IPV4_TOS                8'h00
`define IPV4_TTL                8'h80
`define IPV4_PROTOCOL_UDP       8'h11
`define IPV4_HEADER_BYTES       20
`define UDP_HEADER_BYTES        8

// Reflected CRC-32
`define CRC32_POLY              32'hEDB88320
`define CRC32_INIT              32'hFFFFFFFF

`endif

//--- hw/frame_pkg.sv
package frame_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [15:0] udp_port_t;

    // One complete frame request, captured on acceptance
    typedef struct packed {
        mac_addr_t   mac_destination;
        mac_addr_t   mac_source;
        ipv4_addr_t  ipv4_source;
        ipv4_addr_t  ipv4_destination;
        logic [15:0] identification;
        logic [15:0] flags;
        udp_port_t   udp_source;
        udp_port_t   udp_destination;
        logic [15:0] udp_checksum;
        logic [15:0] payload_length;
    } frame_request_t;

    typedef enum logic [2:0] {
        phase_idle,
        phase_mac_destination,
        phase_mac_source,
        phase_ethertype,
        phase_ipv4_header,
        phase_udp_header,
        phase_payload,
        phase_pad
    } header_state_t;

endpackage

//--- hw/header_serializer.sv
`include "frame_params.svh"

module header_serializer (
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          start_valid,
    output logic                          start_ready,
    input  frame_pkg::frame_request_t     request,
    output logic [`BUFFER_ADDR_WIDTH-1:0] buffer_address,
    input  logic [`FRAME_BYTE_WIDTH-1:0]  buffer_data,
    byte_stream_if.source                 stream
);

    localparam logic [15:0] ethertype = `ETHERTYPE_IPV4;

    frame_pkg::header_state_t     state;
    frame_pkg::frame_request_t    request_q;
    logic [15:0]                  byte_count;
    logic [15:0]                  total_length;
    logic [15:0]                  udp_length;
    logic [15:0]                  ipv4_checksum;
    logic [`FRAME_BYTE_WIDTH-1:0] held_byte;
    logic                         held_valid;
    logic                         accept;
    logic                         fire;
    logic                         field_done;
    logic [159:0]                 ipv4_header;
    logic [63:0]                  udp_header;

    ipv4_header_checksum i_ipv4_header_checksum (
        .request      (request_q),
        .total_length (total_length),
        .checksum     (ipv4_checksum)
    );

    assign accept = start_valid && start_ready;
    assign fire   = stream.valid && stream.ready;

    assign ipv4_header = {`IPV4_VERSION_IHL, `IPV4_TOS, total_length,
                          request_q.identification, request_q.flags,
                          `IPV4_TTL, `IPV4_PROTOCOL_UDP, ipv4_checksum,
                          request_q.ipv4_source, request_q.ipv4_destination};
    assign udp_header  = {request_q.udp_source, request_q.udp_destination,
                          udp_length, request_q.udp_checksum};

    ////////////////////////////////////////////////////////////////////////
    // Byte selection

    always_comb begin
        case (state)
            frame_pkg::phase_mac_destination,
            frame_pkg::phase_mac_source: field_done = byte_count == 16'd5;
            frame_pkg::phase_ethertype:   field_done = byte_count == 16'd1;
            frame_pkg::phase_ipv4_header:
                field_done = byte_count == 16'(`IPV4_HEADER_BYTES - 1);
            frame_pkg::phase_udp_header:
                field_done = byte_count == 16'(`UDP_HEADER_BYTES - 1);
            frame_pkg::phase_payload:
                field_done = byte_count == request_q.payload_length - 16'd1;
            frame_pkg::phase_pad:
                field_done = byte_count == 16'(`MIN_PAYLOAD_BYTES - 1);
            default: field_done = 1'b0;
        endcase
    end

    always_comb begin
        stream.data = '0;
        case (state)
            frame_pkg::phase_mac_destination:
                stream.data = request_q.mac_destination[8 * (5 - byte_count) +: 8];
            frame_pkg::phase_mac_source:
                stream.data = request_q.mac_source[8 * (5 - byte_count) +: 8];
            frame_pkg::phase_ethertype:
                stream.data = ethertype[8 * (1 - byte_count) +: 8];
            frame_pkg::phase_ipv4_header:
                stream.data = ipv4_header[8 * (19 - byte_count) +: 8];
            frame_pkg::phase_udp_header:
                stream.data = udp_header[8 * (7 - byte_count) +: 8];
            // Fresh read unless a stall forced a copy
            frame_pkg::phase_payload:
                stream.data = held_valid ? held_byte : buffer_data;
            default: stream.data = '0;
        endcase
    end

    assign stream.valid = state != frame_pkg::phase_idle;
    assign stream.last  = field_done && ((state == frame_pkg::phase_pad) ||
                          (state == frame_pkg::phase_payload &&
                           request_q.payload_length >= 16'(`MIN_PAYLOAD_BYTES)));

    ////////////////////////////////////////////////////////////////////////
    // Phase sequencing

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= frame_pkg::phase_idle;
            start_ready    <= 1'b0;
            byte_count     <= '0;
            buffer_address <= '0;
            held_valid     <= 1'b0;
        end else begin
            if (accept) begin
                start_ready <= 1'b0;
            end else if (state == frame_pkg::phase_idle || (fire && stream.last)) begin
                start_ready <= 1'b1;
            end

            if (accept) begin
                state          <= frame_pkg::phase_mac_destination;
                byte_count     <= '0;
                buffer_address <= '0;
            end else if (fire) begin
                byte_count <= byte_count + 16'd1;
                if (field_done) begin
                    byte_count <= '0;
                    case (state)
                        frame_pkg::phase_mac_destination: state <= frame_pkg::phase_mac_source;
                        frame_pkg::phase_mac_source:      state <= frame_pkg::phase_ethertype;
                        frame_pkg::phase_ethertype:       state <= frame_pkg::phase_ipv4_header;
                        frame_pkg::phase_ipv4_header:     state <= frame_pkg::phase_udp_header;
                        frame_pkg::phase_udp_header: begin
                            state <= (request_q.payload_length == 16'd0) ?
                                     frame_pkg::phase_pad : frame_pkg::phase_payload;
                        end
                        frame_pkg::phase_payload: begin
                            // Pad continues the data byte count
                            byte_count <= byte_count + 16'd1;
                            state      <= stream.last ? frame_pkg::phase_idle
                                                      : frame_pkg::phase_pad;
                        end
                        default: state <= frame_pkg::phase_idle;
                    endcase
                end
                // Read address runs one byte ahead of the stream
                if (state == frame_pkg::phase_payload ||
                    (state == frame_pkg::phase_udp_header && field_done)) begin
                    buffer_address <= buffer_address + 1'b1;
                end
            end

            if (fire) begin
                held_valid <= 1'b0;
            end else if (state == frame_pkg::phase_payload) begin
                held_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            request_q    <= request;
            total_length <= request.payload_length +
                            16'(`IPV4_HEADER_BYTES + `UDP_HEADER_BYTES);
            udp_length   <= request.payload_length + 16'(`UDP_HEADER_BYTES);
        end
        if (state == frame_pkg::phase_payload && !held_valid && !fire) begin
            held_byte <= buffer_data;
        end
    end

endmodule

//--- hw/ipv4_header_checksum.sv
`include "frame_params.svh"

module ipv4_header_checksum (
    input  frame_pkg::frame_request_t request,
    input  logic [15:0]               total_length,
    output logic [15:0]               checksum
);

    logic [19:0] word_sum;
    logic [16:0] fold_once;
    logic [15:0] fold_twice;

    // Ten header words, checksum word counted as zero
    assign word_sum = 20'({`IPV4_VERSION_IHL, `IPV4_TOS})
                    + 20'(total_length)
                    + 20'(request.identification)
                    + 20'(request.flags)
                    + 20'({`IPV4_TTL, `IPV4_PROTOCOL_UDP})
                    + 20'(16'h0000)
                    + 20'(request.ipv4_source[31:16])
                    + 20'(request.ipv4_source[15:0])
                    + 20'(request.ipv4_destination[31:16])
                    + 20'(request.ipv4_destination[15:0]);

    // Second fold catches the carry out of the first
    assign fold_once  = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
    assign fold_twice = fold_once[15:0] + 16'(fold_once[16]);
    assign checksum   = ~fold_twice;

endmodule

//--- hw/preamble_inserter.sv
`include "frame_params.svh"

module preamble_inserter (
    input  logic          clock,
    input  logic          reset_n,
    byte_stream_if.sink   upstream,
    byte_stream_if.source downstream
);

    logic [3:0] preamble_count;
    logic       in_preamble;

    // Pattern bytes, then delimiter at count PREAMBLE_BYTES
    assign in_preamble = preamble_count <= 4'(`PREAMBLE_BYTES);

    // Starts only once a frame is waiting upstream
    assign downstream.valid = upstream.valid;
    assign downstream.data  = !in_preamble ? upstream.data :
                              (preamble_count == 4'(`PREAMBLE_BYTES)) ? `SFD_BYTE :
                              `PREAMBLE_BYTE;
    assign downstream.last  = !in_preamble && upstream.last;
    assign upstream.ready   = !in_preamble && downstream.ready;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            preamble_count <= '0;
        end else if (downstream.valid && downstream.ready) begin
            if (in_preamble) begin
                preamble_count <= preamble_count + 4'd1;
            end else if (upstream.last) begin
                preamble_count <= '0;
            end
        end
    end

endmodule

//--- sim.f
+incdir+hw
+incdir+verif
hw/frame_pkg.sv
hw/byte_stream_if.sv
hw/ipv4_header_checksum.sv
hw/header_serializer.sv
hw/fcs_appender.sv
hw/preamble_inserter.sv
hw/frame_generator_top.sv
verif/tb_frame_generator.sv

//--- verif/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Uses buffer_mem and expected_q of the including testbench

function automatic int expected_frame_length(input logic [15:0] payload_length);
    int data_bytes;
    data_bytes = (payload_length < `MIN_PAYLOAD_BYTES) ? `MIN_PAYLOAD_BYTES
                                                       : int'(payload_length);
    return `PREAMBLE_BYTES + 1 + 14 + `IPV4_HEADER_BYTES + `UDP_HEADER_BYTES
           + data_bytes + 4;
endfunction

function automatic logic [15:0] ipv4_checksum_ref(input frame_pkg::frame_request_t req);
    logic [31:0] sum;
    logic [15:0] total_length;
    total_length = req.payload_length + 16'(`IPV4_HEADER_BYTES + `UDP_HEADER_BYTES);
    sum = 32'({`IPV4_VERSION_IHL, `IPV4_TOS}) + 32'({`IPV4_TTL, `IPV4_PROTOCOL_UDP})
        + 32'(total_length) + 32'(req.identification) + 32'(req.flags)
        + 32'(req.ipv4_source[31:16]) + 32'(req.ipv4_source[15:0])
        + 32'(req.ipv4_destination[31:16]) + 32'(req.ipv4_destination[15:0]);
    // End-around carry until nothing is left above bit 15
    while (sum[31:16] != 16'd0) begin
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
endfunction

function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] next;
    int          i;
    next = crc;
    for (i = 0; i < 8; i++) begin
        if (next[0] ^ data[i]) begin
            next = (next >> 1) ^ `CRC32_POLY;
        end else begin
            next = next >> 1;
        end
    end
    return next;
endfunction

function automatic void push_expected_frame(input frame_pkg::frame_request_t req);
    logic [335:0] header;
    logic [7:0]   body [$];
    logic [15:0]  total_length;
    logic [15:0]  udp_length;
    logic [31:0]  crc;
    int           data_bytes;
    int           i;
    total_length = req.payload_length + 16'(`IPV4_HEADER_BYTES + `UDP_HEADER_BYTES);
    udp_length   = req.payload_length + 16'(`UDP_HEADER_BYTES);
    header = {req.mac_destination, req.mac_source, `ETHERTYPE_IPV4,
              `IPV4_VERSION_IHL, `IPV4_TOS, total_length, req.identification, req.flags,
              `IPV4_TTL, `IPV4_PROTOCOL_UDP, ipv4_checksum_ref(req),
              req.ipv4_source, req.ipv4_destination,
              req.udp_source, req.udp_destination, udp_length, req.udp_checksum};
    for (i = 41; i >= 0; i--) begin
        body.push_back(header[8 * i +: 8]);
    end
    // Payload read from buffer address zero and zero padded after it
    data_bytes = (req.payload_length < `MIN_PAYLOAD_BYTES) ? `MIN_PAYLOAD_BYTES
                                                           : int'(req.payload_length);
    for (i = 0; i < data_bytes; i++) begin
        body.push_back((i < int'(req.payload_length)) ? buffer_mem[i] : 8'h00);
    end
    crc = `CRC32_INIT;
    for (i = 0; i < body.size(); i++) begin
        crc = crc32_update(crc, body[i]);
    end
    crc = ~crc;
    for (i = 0; i < `PREAMBLE_BYTES; i++) begin
        expected_q.push_back({1'b0, `PREAMBLE_BYTE});
    end
    expected_q.push_back({1'b0, `SFD_BYTE});
    for (i = 0; i < body.size(); i++) begin
        expected_q.push_back({1'b0, body[i]});
    end
    for (i = 0; i < 4; i++) begin
        expected_q.push_back({1'(i == 3), crc[8 * i +: 8]});
    end
endfunction

`endif

//--- verif/tb_frame_generator.sv
`include "frame_params.svh"

module tb_frame_generator;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int request_count = 10;

    logic                          clock;
    logic                          reset_n;
    logic                          start_valid;
    logic                          start_ready;
    frame_pkg::mac_addr_t          mac_destination;
    frame_pkg::mac_addr_t          mac_source;
    frame_pkg::ipv4_addr_t         ipv4_source;
    frame_pkg::ipv4_addr_t         ipv4_destination;
    logic [15:0]                   ipv4_identification;
    logic [15:0]                   ipv4_flags;
    logic [15:0]                   udp_checksum;
    logic [15:0]                   payload_length;
    frame_pkg::udp_port_t          udp_source;
    frame_pkg::udp_port_t          udp_destination;
    logic [`BUFFER_ADDR_WIDTH-1:0] buffer_address;
    logic [`FRAME_BYTE_WIDTH-1:0]  buffer_data;
    logic [`FRAME_BYTE_WIDTH-1:0]  out_data;
    logic                          out_valid;
    logic                          out_last;
    logic                          out_ready;

    logic [7:0]                buffer_mem [0:(1 << `BUFFER_ADDR_WIDTH) - 1];
    logic [8:0]                expected_q [$];
    logic [8:0]                expected_entry;
    frame_pkg::frame_request_t request_list [request_count];
    logic [31:0]               rng_state;
    logic                      random_ready;
    string                     test_name;
    int check_count;
    int error_count;
    int test_checks;
    int test_errors;
    int frames_offered;
    int frames_done;
    int frame_byte;
    int cycle_count;
    int cycle_limit;

    `include "tb_frame_model.svh"

    frame_generator_top i_frame_generator_top (.*);

    always #50 clock = ~clock;

    // Payload memory with one cycle of read latency
    always @(posedge clock) begin
        buffer_data <= buffer_mem[buffer_address];
    end

    always @(posedge clock) begin
        if (random_ready) begin
            out_ready <= next_random() > 32'h7fff_ffff;
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycle_count, test_name);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Comparator sampling mid-cycle ahead of the transfer edge

    always @(negedge clock) begin
        if (reset_n && out_valid && out_ready) begin
            check_count++;
            assert (expected_q.size() > 0) else begin
                $display("Test %s: output byte %02h arrived with no frame outstanding",
                         test_name, out_data);
                error_count++;
            end
            if (expected_q.size() > 0) begin
                expected_entry = expected_q.pop_front();
                assert ({out_last, out_data} === expected_entry) else begin
                    $display("MISMATCH %s frame %0d byte %0d expected %02h/%0b actual %02h/%0b",
                             test_name, frames_done, frame_byte, expected_entry[7:0],
                             expected_entry[8], out_data, out_last);
                    error_count++;
                end
            end
            frame_byte++;
            if (out_last) begin
                frames_done++;
                frame_byte = 0;
            end
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic frame_pkg::frame_request_t random_request(input logic [15:0] length);
        frame_pkg::frame_request_t req;
        int                        word;
        for (word = 0; word < 8; word++) begin
            req[32 * word +: 32] = next_random();
        end
        req.payload_length = length;
        return req;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected %0h actual %0h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    // Called on a rising edge and returns on the edge that accepts the request
    task automatic offer_request(input frame_pkg::frame_request_t req);
        start_valid         <= 1'b1;
        mac_destination     <= req.mac_destination;
        mac_source          <= req.mac_source;
        ipv4_source         <= req.ipv4_source;
        ipv4_destination    <= req.ipv4_destination;
        ipv4_identification <= req.identification;
        ipv4_flags          <= req.flags;
        udp_source          <= req.udp_source;
        udp_destination     <= req.udp_destination;
        udp_checksum        <= req.udp_checksum;
        payload_length      <= req.payload_length;
        @(negedge clock);
        while (!start_ready) begin
            @(negedge clock);
        end
        push_expected_frame(req);
        frames_offered++;
        @(posedge clock);
    endtask

    task automatic wait_for_frames();
        while (frames_done < frames_offered) begin
            @(negedge clock);
        end
    endtask

    task automatic finish_test();
        check_count++;
        assert (expected_q.size() == 0) else begin
            $display("Test %s: %0d expected bytes never arrived", test_name, expected_q.size());
            error_count++;
            expected_q.delete();
        end
        $display("Test %s: %s, %0d checks, %0d errors", test_name,
                 (error_count == test_errors) ? "ok" : "FAILED",
                 check_count - test_checks, error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    initial begin
        int i;
        int total_bytes;
        clock = 1'b0;
        reset_n = 1'b0;
        start_valid = 1'b0;
        mac_destination = '0;
        mac_source = '0;
        ipv4_source = '0;
        ipv4_destination = '0;
        ipv4_identification = '0;
        ipv4_flags = '0;
        udp_source = '0;
        udp_destination = '0;
        udp_checksum = '0;
        payload_length = '0;
        buffer_data = '0;
        out_ready = 1'b1;
        random_ready = 1'b0;
        rng_state = 32'hcf436c19;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        frames_offered = 0;
        frames_done = 0;
        frame_byte = 0;
        cycle_count = 0;
        test_name = "reset";
        for (i = 0; i < (1 << `BUFFER_ADDR_WIDTH); i++) begin
            buffer_mem[i] = 8'((i * 37) ^ (i >> 5));
        end
        total_bytes = 0;
        for (i = 0; i < request_count; i++) begin
            case (i)
                0: request_list[i] = random_request(16'd40);
                1: request_list[i] = random_request(16'd5);
                2: request_list[i] = random_request(16'd18);
                default: request_list[i] = random_request(16'(next_random() % 32'd64));
            endcase
            total_bytes += expected_frame_length(request_list[i].payload_length);
        end
        cycle_limit = 4 * total_bytes + 200;

        @(posedge clock);
        @(negedge clock);
        check_value("out_valid in reset", 32'd0, 32'(out_valid));
        check_value("start_ready in reset", 32'd0, 32'(start_ready));
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        @(negedge clock);
        check_value("start_ready after reset", 32'd1, 32'(start_ready));
        check_value("out_valid after reset", 32'd0, 32'(out_valid));
        finish_test();

        test_name = "frame_40";
        @(posedge clock);
        offer_request(request_list[0]);
        start_valid <= 1'b0;
        wait_for_frames();
        finish_test();

        test_name = "padding";
        for (i = 1; i < 3; i++) begin
            @(posedge clock);
            offer_request(request_list[i]);
            start_valid <= 1'b0;
            wait_for_frames();
        end
        finish_test();

        test_name = "backpressure";
        random_ready = 1'b1;
        for (i = 3; i < 7; i++) begin
            @(posedge clock);
            offer_request(request_list[i]);
            start_valid <= 1'b0;
        end
        wait_for_frames();
        random_ready = 1'b0;
        finish_test();

        // start_valid stays high from one acceptance to the next
        test_name = "back_to_back";
        @(posedge clock);
        for (i = 7; i < request_count; i++) begin
            offer_request(request_list[i]);
        end
        start_valid <= 1'b0;
        wait_for_frames();
        finish_test();

        $display("Total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
